//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = tb_biu_8088
FILELIST   = list.f
OBJ_DIR    = obj_dir
PASS_MSG   = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- biu_8088_top.sv
// 8088-style bus interface unit with sequencer, prefetch window, interrupt ack and hold control
module biu_8088_top (
   input  logic                       clk,
   input  logic                       rst,
   input  biu_pkg::core_req_t         req_i,
   input  logic [biu_pkg::BYTE_W-1:0] ad_i,
   input  logic                       intr_i,
   input  logic                       hold_i,
   output logic                       done_o,
   output logic [biu_pkg::DATA_W-1:0] rdata_o,
   output logic [biu_pkg::ADDR_W-1:0] a_o,
   output biu_pkg::bus_ctl_t          ctl_o,
   output logic [biu_pkg::BYTE_W-1:0] ad_o,
   output logic                       ad_oe_o,
   output logic                       inta_n_o,
   output logic                       hlda_o
);

   logic                       xfer_start;
   biu_pkg::xfer_t             xfer;
   logic                       bus_idle;
   logic                       byte_vld;
   logic [biu_pkg::CNT_W-1:0]  byte_idx;
   logic [biu_pkg::BYTE_W-1:0] byte_val;
   logic                       xfer_end;

   prefetch_queue i_prefetch_queue (
      .clk          (clk),
      .rst          (rst),
      .req_i        (req_i),
      .bus_idle_i   (bus_idle),
      .byte_vld_i   (byte_vld),
      .byte_idx_i   (byte_idx),
      .byte_i       (byte_val),
      .xfer_end_i   (xfer_end),
      .xfer_start_o (xfer_start),
      .xfer_o       (xfer),
      .done_o       (done_o),
      .rdata_o      (rdata_o)
   );

   bus_cycle_seq i_bus_cycle_seq (
      .clk          (clk),
      .rst          (rst),
      .xfer_start_i (xfer_start),
      .xfer_i       (xfer),
      .hlda_i       (hlda_o),
      .ad_i         (ad_i),
      .bus_idle_o   (bus_idle),
      .byte_vld_o   (byte_vld),
      .byte_idx_o   (byte_idx),
      .byte_o       (byte_val),
      .xfer_end_o   (xfer_end),
      .a_o          (a_o),
      .ctl_o        (ctl_o),
      .ad_o         (ad_o),
      .ad_oe_o      (ad_oe_o)
   );

   intr_ack_seq i_intr_ack_seq (
      .clk      (clk),
      .rst      (rst),
      .intr_i   (intr_i),
      .inta_n_o (inta_n_o)
   );

   hold_ctrl i_hold_ctrl (
      .clk        (clk),
      .rst        (rst),
      .hold_i     (hold_i),
      .bus_idle_i (bus_idle),
      .hlda_o     (hlda_o)
   );

endmodule

//--- biu_pkg.sv
// bus interface unit package with widths, window size, reset base, request/strobe/order structs, sequencer states
package biu_pkg;

   localparam int ADDR_W = 20;
   localparam int DATA_W = 16;
   localparam int BYTE_W = 8;
   localparam int CNT_W  = 3;

   localparam logic [CNT_W-1:0] FETCH_BYTES = 3'd4;        // window size and fill length
   localparam int WIN_IDX_W = $clog2(FETCH_BYTES);         // index into the window bytes

   localparam logic [ADDR_W-1:0] RESET_BASE = 20'hFFFF0;   // reset vector area

   // core request held as levels until done
   typedef struct packed {
      logic              rd;
      logic              wr;
      logic              byte_op;   // 1 byte, 0 word
      logic              m_io;      // 1 memory, 0 io
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] wdata;
   } core_req_t;

   // external strobes
   typedef struct packed {
      logic ale;
      logic rd_n;
      logic wr_n;
      logic den_n;
      logic dtr;
      logic iom;
   } bus_ctl_t;

   // transfer order from the queue to the sequencer
   typedef struct packed {
      logic              is_wr;
      logic              m_io;
      logic [ADDR_W-1:0] adr;
      logic [CNT_W-1:0]  nbytes;
      logic [DATA_W-1:0] wdata;
   } xfer_t;

   typedef enum logic [2:0] {
      idle,
      t1_addr,
      t2_strobe,
      t3_latch,
      t4_end
   } seq_state_t;

endpackage

//--- bus_cycle_seq.sv
// T1-T4 byte cycle state machine with byte counter, strobes and multiplexed ad drive
module bus_cycle_seq (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       xfer_start_i,
   input  biu_pkg::xfer_t             xfer_i,
   input  logic                       hlda_i,
   input  logic [biu_pkg::BYTE_W-1:0] ad_i,
   output logic                       bus_idle_o,
   output logic                       byte_vld_o,
   output logic [biu_pkg::CNT_W-1:0]  byte_idx_o,
   output logic [biu_pkg::BYTE_W-1:0] byte_o,
   output logic                       xfer_end_o,
   output logic [biu_pkg::ADDR_W-1:0] a_o,
   output biu_pkg::bus_ctl_t          ctl_o,
   output logic [biu_pkg::BYTE_W-1:0] ad_o,
   output logic                       ad_oe_o
);

   biu_pkg::seq_state_t state_q;
   logic [biu_pkg::CNT_W-1:0] cnt_q;
   logic [biu_pkg::CNT_W-1:0] cnt_nxt;
   biu_pkg::xfer_t ord_q;                   // order copy for the whole transfer
   logic [biu_pkg::BYTE_W-1:0] rbyte_q;
   logic end_q;
   logic accept;
   logic last_byte;
   logic [biu_pkg::BYTE_W-1:0] wbyte;

   assign accept    = (state_q == biu_pkg::idle) & xfer_start_i & ~hlda_i;  // held off under hold
   assign cnt_nxt   = cnt_q + {{(biu_pkg::CNT_W-1){1'b0}}, 1'b1};
   assign last_byte = (cnt_nxt == ord_q.nbytes);

   // idle only once the end pulse is out and no order is being taken
   assign bus_idle_o = (state_q == biu_pkg::idle) & ~end_q & ~accept;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state_q <= biu_pkg::idle;
         cnt_q   <= '0;
         end_q   <= 1'b0;
      end else begin
         end_q <= 1'b0;
         case (state_q)
            biu_pkg::idle: begin
               if (accept) begin
                  state_q <= biu_pkg::t1_addr;
                  cnt_q   <= '0;
               end
            end
            biu_pkg::t1_addr:   state_q <= biu_pkg::t2_strobe;
            biu_pkg::t2_strobe: state_q <= biu_pkg::t3_latch;
            biu_pkg::t3_latch:  state_q <= biu_pkg::t4_end;
            biu_pkg::t4_end: begin
               if (last_byte) begin
                  state_q <= biu_pkg::idle;
                  end_q   <= 1'b1;
               end else begin
                  state_q <= biu_pkg::t1_addr;   // next byte
                  cnt_q   <= cnt_nxt;
               end
            end
            default: state_q <= biu_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         ord_q <= xfer_i;
      if (state_q == biu_pkg::t3_latch && !ord_q.is_wr)
         rbyte_q <= ad_i;                    // sampled at the end of T3
   end

   assign a_o   = ord_q.adr + {{(biu_pkg::ADDR_W-biu_pkg::CNT_W){1'b0}}, cnt_q};
   assign wbyte = (cnt_q == '0) ? ord_q.wdata[biu_pkg::BYTE_W-1:0]
                                : ord_q.wdata[biu_pkg::DATA_W-1:biu_pkg::BYTE_W];

   assign byte_vld_o = (state_q == biu_pkg::t4_end) & ~ord_q.is_wr;
   assign byte_idx_o = cnt_q;
   assign byte_o     = rbyte_q;
   assign xfer_end_o = end_q;

   always_comb begin
      ctl_o.ale   = 1'b0;
      ctl_o.rd_n  = 1'b1;
      ctl_o.wr_n  = 1'b1;
      ctl_o.den_n = 1'b1;
      ctl_o.dtr   = 1'b1;
      ctl_o.iom   = 1'b0;
      ad_o        = '0;
      ad_oe_o     = 1'b0;
      if (state_q != biu_pkg::idle) begin
         ctl_o.iom = ~ord_q.m_io;
         ctl_o.dtr = ord_q.is_wr;           // low while reading
      end
      case (state_q)
         biu_pkg::t1_addr: begin
            ctl_o.ale = 1'b1;
            ad_o      = a_o[biu_pkg::BYTE_W-1:0];
            ad_oe_o   = 1'b1;
         end
         biu_pkg::t2_strobe, biu_pkg::t3_latch: begin
            ctl_o.rd_n  = ord_q.is_wr;
            ctl_o.wr_n  = ~ord_q.is_wr;
            ctl_o.den_n = 1'b0;
            ad_o        = ord_q.is_wr ? wbyte : '0;
            ad_oe_o     = ord_q.is_wr;
         end
         biu_pkg::t4_end: begin
            ad_o    = ord_q.is_wr ? wbyte : '0;   // write data held through T4
            ad_oe_o = ord_q.is_wr;
         end
         default: ;
      endcase
   end

endmodule

//--- hold_ctrl.sv
// hold request sequencer with settle delay and hlda grant on an idle bus
module hold_ctrl (
   input  logic clk,
   input  logic rst,
   input  logic hold_i,
   input  logic bus_idle_i,
   output logic hlda_o
);

   typedef enum logic [1:0] {
      hc_idle,
      hc_settle,
      hc_granted
   } hc_state_t;

   hc_state_t state_q;
   logic [1:0] cnt_q;    // settle cycles seen

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state_q <= hc_idle;
         cnt_q   <= 2'd0;
      end else begin
         case (state_q)
            hc_idle: begin
               if (hold_i) begin
                  state_q <= hc_settle;
                  cnt_q   <= 2'd0;
               end
            end
            hc_settle: begin
               if (!hold_i)
                  state_q <= hc_idle;       // request withdrawn
               else if (cnt_q != 2'd2)
                  cnt_q <= cnt_q + 2'd1;
               else if (bus_idle_i)
                  state_q <= hc_granted;
            end
            hc_granted: begin
               if (!hold_i)
                  state_q <= hc_idle;
            end
            default: state_q <= hc_idle;
         endcase
      end
   end

   // the sequencer stays in idle while this is high
   assign hlda_o = (state_q == hc_granted);

endmodule

//--- intr_ack_seq.sv
// interrupt acknowledge sequencer with two-cycle inta_n pulse and recovery cycle
module intr_ack_seq (
   input  logic clk,
   input  logic rst,
   input  logic intr_i,
   output logic inta_n_o
);

   typedef enum logic {
      ia_idle,
      ia_ack
   } ia_state_t;

   ia_state_t state_q;
   logic [1:0] cnt_q;    // acknowledge cycles then recovery

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state_q <= ia_idle;
         cnt_q   <= 2'd0;
      end else begin
         case (state_q)
            ia_idle: begin
               if (intr_i) begin
                  state_q <= ia_ack;
                  cnt_q   <= 2'd0;
               end
            end
            ia_ack: begin
               if (cnt_q == 2'd2)
                  state_q <= ia_idle;   // recovery done
               else
                  cnt_q <= cnt_q + 2'd1;
            end
            default: state_q <= ia_idle;
         endcase
      end
   end

   assign inta_n_o = ~((state_q == ia_ack) & (cnt_q != 2'd2));

endmodule

//--- list.f
biu_pkg.sv
bus_cycle_seq.sv
prefetch_queue.sv
intr_ack_seq.sv
hold_ctrl.sv
biu_8088_top.sv
tb_biu_8088.sv

//--- prefetch_queue.sv
// request intake, four-byte fetch window with hit test, transfer orders, read data assembly
module prefetch_queue (
   input  logic                       clk,
   input  logic                       rst,
   input  biu_pkg::core_req_t         req_i,
   input  logic                       bus_idle_i,
   input  logic                       byte_vld_i,
   input  logic [biu_pkg::CNT_W-1:0]  byte_idx_i,
   input  logic [biu_pkg::BYTE_W-1:0] byte_i,
   input  logic                       xfer_end_i,
   output logic                       xfer_start_o,
   output biu_pkg::xfer_t             xfer_o,
   output logic                       done_o,
   output logic [biu_pkg::DATA_W-1:0] rdata_o
);

   logic [biu_pkg::ADDR_W-1:0] base_q;
   logic [biu_pkg::BYTE_W-1:0] win_q [biu_pkg::FETCH_BYTES];
   logic [biu_pkg::BYTE_W-1:0] io_q [2];        // io read bytes kept outside the window
   logic vld_q;
   logic pend_q;                                 // request taken and not yet done
   logic want_q;                                 // order waiting for the sequencer
   logic done_q;
   logic [biu_pkg::DATA_W-1:0] rdata_q;

   logic [biu_pkg::ADDR_W-1:0] off;
   logic [biu_pkg::CNT_W-1:0] off_lo;
   logic off_hi_zero;
   logic [biu_pkg::CNT_W-1:0] need;
   logic [biu_pkg::WIN_IDX_W-1:0] lo_idx;
   logic [biu_pkg::WIN_IDX_W-1:0] hi_idx;
   logic in_win;
   logic new_req;
   logic hit;
   logic fill;
   logic overlap;
   logic [biu_pkg::BYTE_W-1:0] lo_b;
   logic [biu_pkg::BYTE_W-1:0] hi_b;
   logic [biu_pkg::DATA_W-1:0] rd_word;

   assign off         = req_i.adr - base_q;
   assign off_lo      = off[biu_pkg::CNT_W-1:0];
   assign off_hi_zero = (off[biu_pkg::ADDR_W-1:biu_pkg::CNT_W] == '0);
   assign need        = req_i.byte_op ? 3'd1 : 3'd2;

   // whole access must sit inside the window
   assign in_win = off_hi_zero &
                   (({1'b0, off_lo} + {1'b0, need}) <= {1'b0, biu_pkg::FETCH_BYTES});

   assign new_req = (req_i.rd | req_i.wr) & ~pend_q;
   assign hit     = vld_q & req_i.rd & req_i.m_io & in_win;
   assign fill    = req_i.rd & req_i.m_io & ~hit;   // memory read miss

   // a word write one below the base still touches byte 0
   assign overlap = req_i.wr & req_i.m_io &
                    ((off_hi_zero & (off_lo < biu_pkg::FETCH_BYTES)) |
                     (~req_i.byte_op & (&off)));

   assign lo_idx = off[biu_pkg::WIN_IDX_W-1:0];
   assign hi_idx = lo_idx + {{(biu_pkg::WIN_IDX_W-1){1'b0}}, 1'b1};

   always_comb begin
      lo_b = req_i.m_io ? win_q[lo_idx] : io_q[0];
      hi_b = req_i.m_io ? win_q[hi_idx] : io_q[1];
      if (req_i.byte_op)
         rd_word = {{(biu_pkg::DATA_W-biu_pkg::BYTE_W){lo_b[biu_pkg::BYTE_W-1]}}, lo_b};
      else
         rd_word = {hi_b, lo_b};                 // low byte first on the bus
   end

   always_comb begin
      xfer_o.is_wr  = req_i.wr;
      xfer_o.m_io   = req_i.m_io;
      xfer_o.adr    = req_i.adr;
      xfer_o.nbytes = fill ? biu_pkg::FETCH_BYTES : need;
      xfer_o.wdata  = req_i.wdata;
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         base_q <= biu_pkg::RESET_BASE;
         vld_q  <= 1'b0;
         pend_q <= 1'b0;
         want_q <= 1'b0;
         done_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (new_req) begin
            pend_q <= 1'b1;
            if (hit)
               done_q <= 1'b1;                  // served from the window
            else
               want_q <= 1'b1;
            if (fill) begin
               base_q <= req_i.adr;             // window restarts at the miss
               vld_q  <= 1'b0;
            end
            if (overlap)
               vld_q <= 1'b0;
         end
         if (want_q && !bus_idle_i)
            want_q <= 1'b0;                      // sequencer took it
         if (xfer_end_i) begin
            done_q <= 1'b1;
            if (fill)
               vld_q <= 1'b1;
         end
         if (done_q)
            pend_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (byte_vld_i) begin
         if (fill)
            win_q[byte_idx_i[biu_pkg::WIN_IDX_W-1:0]] <= byte_i;
         else
            io_q[byte_idx_i[0]] <= byte_i;
      end
      if ((new_req && hit) || xfer_end_i)
         rdata_q <= rd_word;
   end

   assign xfer_start_o = want_q;
   assign done_o       = done_q;
   assign rdata_o      = rdata_q;

endmodule

//--- tb_biu_8088.sv
// testbench for biu_8088_top with clock, bus memory model, reference read function, stimulus and checks
module tb_biu_8088;
   timeunit 1ns;
   timeprecision 1ps;

   logic clk = 1'b0;
   logic rst;
   logic intr_i;
   logic hold_i;
   biu_pkg::core_req_t req_i;
   biu_pkg::bus_ctl_t ctl_o;
   logic done_o;
   logic ad_oe_o;
   logic inta_n_o;
   logic hlda_o;
   logic [biu_pkg::DATA_W-1:0] rdata_o;
   logic [biu_pkg::ADDR_W-1:0] a_o;
   logic [7:0] ad_i;
   logic [7:0] ad_o;

   logic [7:0] mem [256];      // memory space, indexed by the low address byte
   logic [7:0] io_mem [16];
   logic [7:0] sh_mem [256];   // expected contents
   logic [7:0] sh_io [16];
   logic [biu_pkg::ADDR_W-1:0] win_base;
   logic win_vld;
   logic [31:0] seed_q = 32'd33;
   logic chk_rd = 1'b0;
   logic chk_wr = 1'b0;
   logic chk_io = 1'b0;
   logic [15:0] chk_exp = 16'h0000;
   logic [19:0] exp_adr = 20'h00000;   // start address of the running request
   int ale_base = 0;
   int ale_total = 0;
   int stim_err = 0;
   int mon_err = 0;
   int cmp_err = 0;
   int n_pass = 0;
   int n_fail = 0;

   always #20 clk = ~clk;

   biu_8088_top i_biu_8088_top (.*);

   function automatic logic [7:0] mem_fill(input int i);
      return 8'((i * 29) ^ (i >> 2) ^ 165);
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   // expected read data with low byte first and bytes sign-extended
   function automatic logic [15:0] exp_read(input logic [19:0] adr, input logic bop,
                                            input logic mio);
      logic [7:0] lo;
      logic [7:0] hi;
      lo = mio ? sh_mem[adr[7:0]] : sh_io[adr[3:0]];
      hi = mio ? sh_mem[adr[7:0] + 8'd1] : sh_io[adr[3:0] + 4'd1];
      if (bop)
         return {{8{lo[7]}}, lo};
      return {hi, lo};
   endfunction

   function automatic int check_val(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
      int bad;
      bad = 0;
      assert (got === exp) else begin
         $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
         bad = 1;
      end
      return bad;
   endfunction

   function automatic bit in_window(input logic [19:0] adr, input int need);
      return win_vld && adr >= win_base &&
             int'(adr - win_base) + need <= int'(biu_pkg::FETCH_BYTES);
   endfunction

   function automatic int all_err();
      return stim_err + mon_err + cmp_err;
   endfunction

   // bus model drives ad_i while rd_n is low
   assign ad_i = ctl_o.rd_n ? 8'h00 : (ctl_o.iom ? io_mem[a_o[3:0]] : mem[a_o[7:0]]);

   always @(posedge clk) begin
      if (!rst) begin
         for (int i = 0; i < 256; i++)
            mem[i] <= mem_fill(i);
         for (int i = 0; i < 16; i++)
            io_mem[i] <= mem_fill(i + 300);
      end else if (!ctl_o.wr_n) begin
         if (ctl_o.iom)
            io_mem[a_o[3:0]] <= ad_o;   // io space
         else
            mem[a_o[7:0]] <= ad_o;
      end
   end

   // counts byte cycles and checks the strobes and address seen at ale
   always @(negedge clk) begin
      logic [19:0] badr;
      if (rst && ctl_o.ale) begin
         badr = exp_adr + 20'(ale_total - ale_base);
         ale_total++;
         assert (!hlda_o) else begin
            $display("Bus cycle started at %0t while hlda_o was high", $time);
            mon_err++;
         end
         mon_err += check_val("iom", 32'(ctl_o.iom), 32'(chk_io));
         mon_err += check_val("dtr", 32'(ctl_o.dtr), 32'(chk_wr));
         mon_err += check_val("wr_n", 32'(ctl_o.wr_n), 32'd1);
         mon_err += check_val("a_o", 32'(a_o), 32'(badr));
         mon_err += check_val("ad_o", 32'(ad_o), 32'(badr[7:0]));
         mon_err += check_val("ad_oe_o", 32'(ad_oe_o), 32'd1);
      end
   end

   always @(negedge clk) begin
      if (rst && done_o && chk_rd)
         cmp_err += check_val("rdata_o", 32'(rdata_o), 32'(chk_exp));
   end

   task automatic run_req(input logic rd, input logic bop, input logic mio,
                          input logic [19:0] adr, input logic [15:0] wd);
      int need;
      int exp_ales;
      int ale_start;
      int w;
      need = bop ? 1 : 2;
      exp_ales = need;
      if (rd && mio) begin
         if (in_window(adr, need)) begin
            exp_ales = 0;
         end else begin
            exp_ales = int'(biu_pkg::FETCH_BYTES);   // miss refills from adr
            win_base = adr;
            win_vld = 1'b1;
         end
      end else if (mio && int'(adr) < int'(win_base) + int'(biu_pkg::FETCH_BYTES) &&
                   int'(adr) + need > int'(win_base)) begin
         win_vld = 1'b0;
      end
      if (!rd && mio) begin
         sh_mem[adr[7:0]] = wd[7:0];
         if (!bop)
            sh_mem[adr[7:0] + 8'd1] = wd[15:8];
      end else if (!rd) begin
         sh_io[adr[3:0]] = wd[7:0];
         if (!bop)
            sh_io[adr[3:0] + 4'd1] = wd[15:8];
      end
      chk_exp = exp_read(adr, bop, mio);
      chk_rd = rd;
      chk_wr = !rd;
      chk_io = !mio;
      ale_start = ale_total;
      ale_base = ale_total;
      exp_adr = adr;
      req_i = '{rd: rd, wr: !rd, byte_op: bop, m_io: mio, adr: adr, wdata: wd};
      w = 0;
      do begin
         @(negedge clk);
         w++;
      end while (!done_o && w < 300);
      if (!done_o) begin
         $display("Timeout: request at address %h never got done_o", adr);
         stim_err++;
      end
      req_i = '0;
      stim_err += check_val("ale count", 32'(ale_total - ale_start), 32'(exp_ales));
      if (!rd && mio) begin
         stim_err += check_val("mem low byte", 32'(mem[adr[7:0]]), 32'(sh_mem[adr[7:0]]));
         stim_err += check_val("mem high byte", 32'(mem[adr[7:0] + 8'd1]),
                               32'(sh_mem[adr[7:0] + 8'd1]));
      end
      @(negedge clk);
   endtask

   task automatic report_test(input string name, input int err_before);
      if (all_err() == err_before) begin
         $display("test %s passed", name);
         n_pass++;
      end else begin
         $display("test %s failed with %0d errors", name, all_err() - err_before);
         n_fail++;
      end
   endtask

   initial begin
      int e0;
      int w;
      int a0;
      rst = 1'b0;
      intr_i = 1'b0;
      hold_i = 1'b0;
      req_i = '0;
      win_base = biu_pkg::RESET_BASE;
      win_vld = 1'b0;
      for (int i = 0; i < 256; i++)
         sh_mem[i] = mem_fill(i);
      for (int i = 0; i < 16; i++)
         sh_io[i] = mem_fill(i + 300);
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;
      @(negedge clk);

      e0 = all_err();
      stim_err += check_val("ale,rd_n,wr_n,den_n,ad_oe_o,done_o,inta_n_o,hlda_o",
                            32'({ctl_o.ale, ctl_o.rd_n, ctl_o.wr_n, ctl_o.den_n, ad_oe_o,
                                 done_o, inta_n_o, hlda_o}), 32'h72);
      report_test("reset", e0);

      e0 = all_err();
      repeat (6) begin
         seed_q = xorshift32(seed_q);
         if (in_window({16'h0100, seed_q[3:0]}, 1))
            run_req(1'b1, seed_q[4], 1'b1, {16'h0100, seed_q[3:0]} + 20'h8, 16'h0000);
         else
            run_req(1'b1, seed_q[4], 1'b1, {16'h0100, seed_q[3:0]}, 16'h0000);
      end
      report_test("read_miss", e0);

      e0 = all_err();
      run_req(1'b1, 1'b0, 1'b1, 20'h01040, 16'h0000);   // fills 1040..1043
      run_req(1'b1, 1'b1, 1'b1, 20'h01043, 16'h0000);
      run_req(1'b1, 1'b0, 1'b1, 20'h01041, 16'h0000);
      run_req(1'b1, 1'b0, 1'b1, 20'h01042, 16'h0000);
      run_req(1'b1, 1'b1, 1'b1, 20'h01040, 16'h0000);
      report_test("read_hit", e0);

      e0 = all_err();
      repeat (40) begin
         seed_q = xorshift32(seed_q);
         case (seed_q[6:5])
            2'd0, 2'd1: begin
               run_req(1'b0, seed_q[4], 1'b1, {16'h0100, seed_q[3:0]}, seed_q[31:16]);
               run_req(1'b1, seed_q[4], 1'b1, {16'h0100, seed_q[3:0]}, 16'h0000);
            end
            2'd2: run_req(1'b1, seed_q[4], 1'b1, {16'h0100, seed_q[3:0]}, 16'h0000);
            default: begin
               // io access and then an io read of the same port
               run_req(seed_q[7], seed_q[4], 1'b0, {16'h0000, seed_q[11:8]}, seed_q[31:16]);
               run_req(1'b1, seed_q[4], 1'b0, {16'h0000, seed_q[11:8]}, 16'h0000);
            end
         endcase
      end
      report_test("random_rw", e0);

      e0 = all_err();
      repeat (3) begin
         stim_err += check_val("inta_n_o idle", 32'(inta_n_o), 32'd1);
         intr_i = 1'b1;
         @(negedge clk);
         intr_i = 1'b0;
         stim_err += check_val("inta_n_o cycle 1", 32'(inta_n_o), 32'd0);
         @(negedge clk);
         stim_err += check_val("inta_n_o cycle 2", 32'(inta_n_o), 32'd0);
         @(negedge clk);
         stim_err += check_val("inta_n_o recovery", 32'(inta_n_o), 32'd1);
         @(negedge clk);
      end
      report_test("intr_ack", e0);

      e0 = all_err();
      fork
         run_req(1'b1, 1'b0, 1'b1, 20'h01060, 16'h0000);
         begin
            repeat (4) @(negedge clk);
            hold_i = 1'b1;   // raised mid transfer
            w = 0;
            while (!done_o && w < 300) begin
               stim_err += check_val("hlda_o before done_o", 32'(hlda_o), 32'd0);
               @(negedge clk);
               w++;
            end
            if (!done_o) begin
               $display("Timeout: transfer under hold never got done_o");
               stim_err++;
            end
            w = 0;
            while (!hlda_o && w < 50) begin
               @(negedge clk);
               w++;
            end
            if (!hlda_o) begin
               $display("Timeout: hlda_o never rose while hold_i was high");
               stim_err++;
            end
         end
      join
      a0 = ale_total;
      fork
         run_req(1'b1, 1'b1, 1'b1, 20'h01070, 16'h0000);
         begin
            repeat (6) @(negedge clk);
            stim_err += check_val("hlda_o under hold", 32'(hlda_o), 32'd1);
            stim_err += check_val("done_o under hold", 32'(done_o), 32'd0);
            stim_err += check_val("ale count under hold", 32'(ale_total - a0), 32'd0);
            hold_i = 1'b0;
            @(negedge clk);
            stim_err += check_val("hlda_o after release", 32'(hlda_o), 32'd0);
         end
      join
      report_test("hold", e0);

      $display("tests passed %0d, tests failed %0d, errors %0d", n_pass, n_fail, all_err());
      if (all_err() == 0 && n_fail == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
